//--- filelist.f
logic/dzBusPkg.sv
logic/dzRegPkg.sv
logic/dzTxLine.sv
logic/dzRxSilo.sv
logic/dzCsr.sv
logic/dzMux.sv
dv/dzMuxTb.sv

//--- Makefile
# Verilator build for the DZ mux testbench

VERILATOR ?= verilator
TOP       ?= dzMuxTb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= *** PASSED ***

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BINARY))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_STR)'

clean:
	rm -rf $(OBJ_DIR)

//--- dv/dzMuxTb.sv
// Directed testbench for the DZ mux, bus and receive inputs driven on the falling edge
// Stops at the first mismatch, received characters come from a fixed seed
module dzMuxTb;

   timeunit 1ns;
   timeprecision 1ps;

   // Directed traffic is a few hundred cycles, ample margin on top
   localparam int timeoutCycles = 4000;

   logic                clk;
   logic                rst;
   logic                devReset;
   logic                wrStrobe;
   logic                rdStrobe;
   dzBusPkg::regAddr_t  addr;
   logic                loByte;
   logic                hiByte;
   dzBusPkg::busWord_t  wrData;
   dzBusPkg::busWord_t  rdData;
   logic                rxStrobe;
   dzRegPkg::lineNum_t  rxLine;
   dzRegPkg::char_t     rxChar;
   dzRegPkg::lineMask_t txStrobe;
   dzRegPkg::char_t     txChar;
   int                  cycleCount;
   // RBUF words still expected from the silo, oldest first
   dzBusPkg::busWord_t  expRbuf[$];

   dzMux i_dut (
      .clk      (clk),
      .rst      (rst),
      .devReset (devReset),
      .wrStrobe (wrStrobe),
      .rdStrobe (rdStrobe),
      .addr     (addr),
      .loByte   (loByte),
      .hiByte   (hiByte),
      .wrData   (wrData),
      .rdData   (rdData),
      .rxStrobe (rxStrobe),
      .rxLine   (rxLine),
      .rxChar   (rxChar),
      .txStrobe (txStrobe),
      .txChar   (txChar)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial
   begin
      cycleCount = 0;
      forever
      begin
         @(posedge clk);
         cycleCount++;
         if (cycleCount >= timeoutCycles)
            failRun("Timeout: the directed tests did not finish in time");
      end
   end

   ////////////////////
   // Helpers
   ////////////////////

   task automatic failRun(input string reason);
      $display("%s", reason);
      $display("*** FAILED ***");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check(input string name, input logic [15:0] got,
                        input logic [15:0] expected);
      if (got !== expected)
         failRun($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, expected));
   endtask

   // One CSR bit as a word
   function automatic dzBusPkg::busWord_t bitMask(input int idx);
      return dzBusPkg::busWord_t'(1) << idx;
   endfunction

   // RBUF word with DVAL and OVRN, three spare bits, line in 10:8 and character in 7:0
   function automatic dzBusPkg::busWord_t rbufWord(input logic ovrn,
                                                   input dzRegPkg::lineNum_t line,
                                                   input dzRegPkg::char_t c);
      return {1'b1, ovrn, 3'b000, line, c};
   endfunction

   task automatic busWrite(input dzBusPkg::regAddr_t a, input logic lo, input logic hi,
                           input dzBusPkg::busWord_t d);
      @(negedge clk);
      wrStrobe = 1'b1;
      addr     = a;
      loByte   = lo;
      hiByte   = hi;
      wrData   = d;
      @(negedge clk);
      wrStrobe = 1'b0;
      loByte   = 1'b0;
      hiByte   = 1'b0;
   endtask

   // rdData is registered, valid at the falling edge after the strobe
   task automatic busRead(input dzBusPkg::regAddr_t a, output dzBusPkg::busWord_t d);
      @(negedge clk);
      rdStrobe = 1'b1;
      addr     = a;
      @(negedge clk);
      rdStrobe = 1'b0;
      d        = rdData;
   endtask

   task automatic sendRx(input dzRegPkg::lineNum_t line, input dzRegPkg::char_t c);
      @(negedge clk);
      rxStrobe = 1'b1;
      rxLine   = line;
      rxChar   = c;
      @(negedge clk);
      rxStrobe = 1'b0;
   endtask

   // Read CSR until one bit shows the wanted value
   task automatic pollCsr(input int bitIdx, input logic want, input int limit,
                          input string what, output dzBusPkg::busWord_t csr);
      int tries;
      tries = 0;
      busRead(dzBusPkg::addrCsr, csr);
      while (csr[bitIdx] !== want)
      begin
         tries++;
         if (tries >= limit)
            failRun($sformatf("%s not seen within %0d CSR reads", what, limit));
         else
            busRead(dzBusPkg::addrCsr, csr);
      end
   endtask

   // Every expected entry in order, then an empty read
   task automatic drainRbuf();
      dzBusPkg::busWord_t d;
      while (expRbuf.size() > 0)
      begin
         busRead(dzBusPkg::addrRbuf, d);
         check("RBUF", d, expRbuf.pop_front());
      end
      busRead(dzBusPkg::addrRbuf, d);
      check("RBUF", d, 16'h0000);
   endtask

   // CLR one-shot, wait for it to end
   task automatic clearDevice();
      dzBusPkg::busWord_t d;
      busWrite(dzBusPkg::addrCsr, 1'b1, 1'b0, bitMask(dzRegPkg::csrClrBit));
      pollCsr(dzRegPkg::csrClrBit, 1'b0, dzRegPkg::clrCycles + 4, "CLR end", d);
      expRbuf.delete();
   endtask

   ////////////////////
   // Directed tests
   ////////////////////

   task automatic regAccess();
      dzBusPkg::busWord_t d;
      dzBusPkg::busWord_t hiBits;
      dzBusPkg::busWord_t loBits;
      hiBits = bitMask(dzRegPkg::csrTieBit) | bitMask(dzRegPkg::csrSaeBit);
      loBits = bitMask(dzRegPkg::csrRieBit) | bitMask(dzRegPkg::csrMseBit)
               | bitMask(dzRegPkg::csrMaintBit);
      check("rdData", rdData, 16'h0000);
      check("txStrobe", 16'(txStrobe), 16'h0000);
      busRead(dzBusPkg::addrCsr, d);
      check("CSR", d, 16'h0000);
      busRead(dzBusPkg::addrTcr, d);
      check("TCR", d, 16'h0000);
      // High lane alone, only TIE and SAE land
      busWrite(dzBusPkg::addrCsr, 1'b0, 1'b1, 16'hffff);
      busRead(dzBusPkg::addrCsr, d);
      check("CSR", d, hiBits);
      // Low lane without CLR, high data bits zero so TIE and SAE must survive
      busWrite(dzBusPkg::addrCsr, 1'b1, 1'b0, 16'h00ef);
      busRead(dzBusPkg::addrCsr, d);
      check("CSR", d, hiBits | loBits);
      busWrite(dzBusPkg::addrCsr, 1'b1, 1'b1, 16'h0000);
      busRead(dzBusPkg::addrCsr, d);
      check("CSR", d, 16'h0000);
      busWrite(dzBusPkg::addrTcr, 1'b1, 1'b1, 16'ha55a);
      busRead(dzBusPkg::addrTcr, d);
      check("TCR", d, 16'ha55a);
      busWrite(dzBusPkg::addrTcr, 1'b1, 1'b1, 16'h0000);
   endtask

   task automatic clearOneShot();
      dzBusPkg::busWord_t d;
      busWrite(dzBusPkg::addrTcr, 1'b1, 1'b1, 16'h00ff);
      busWrite(dzBusPkg::addrCsr, 1'b1, 1'b1, 16'h5078);
      busRead(dzBusPkg::addrCsr, d);
      check("CSR.CLR", 16'(d[dzRegPkg::csrClrBit]), 16'h0001);
      pollCsr(dzRegPkg::csrClrBit, 1'b0, dzRegPkg::clrCycles + 4, "CLR end", d);
      check("CSR", d, 16'h0000);
      busRead(dzBusPkg::addrTcr, d);
      check("TCR", d, 16'h0000);
   endtask

   task automatic txScanner();
      dzBusPkg::busWord_t d;
      dzRegPkg::char_t    c;
      c = dzRegPkg::char_t'($urandom);
      // Lines 2 and 5 enabled
      busWrite(dzBusPkg::addrTcr, 1'b1, 1'b1, 16'h0024);
      busWrite(dzBusPkg::addrCsr, 1'b1, 1'b0, bitMask(dzRegPkg::csrMseBit));
      pollCsr(dzRegPkg::csrTrdyBit, 1'b1, dzRegPkg::numLines + 4, "TRDY", d);
      check("CSR.TLINE", 16'(d[dzRegPkg::csrTlineLsb +: 3]), 16'd2);
      busWrite(dzBusPkg::addrTdr, 1'b1, 1'b0, {8'h00, c});
      check("txStrobe", 16'(txStrobe), 16'h0004);
      check("txChar", 16'(txChar), 16'(c));
      @(negedge clk);
      check("txStrobe", 16'(txStrobe), 16'h0000);
      // Line 2 busy now, scanner moves on
      pollCsr(dzRegPkg::csrTrdyBit, 1'b1, dzRegPkg::numLines + 4, "TRDY", d);
      check("CSR.TLINE", 16'(d[dzRegPkg::csrTlineLsb +: 3]), 16'd5);
      busWrite(dzBusPkg::addrCsr, 1'b1, 1'b1, 16'h0000);
      repeat (dzRegPkg::numLines)
      begin
         busRead(dzBusPkg::addrCsr, d);
         check("CSR.TRDY", 16'(d[dzRegPkg::csrTrdyBit]), 16'h0000);
      end
   endtask

   task automatic lineDrop();
      dzBusPkg::busWord_t d;
      busWrite(dzBusPkg::addrCsr, 1'b1, 1'b0, bitMask(dzRegPkg::csrMseBit));
      pollCsr(dzRegPkg::csrTrdyBit, 1'b1, dzRegPkg::numLines + 4, "TRDY", d);
      busWrite(dzBusPkg::addrTcr, 1'b1, 1'b1, 16'h0000);
      pollCsr(dzRegPkg::csrTrdyBit, 1'b0, 2, "TRDY drop", d);
      busWrite(dzBusPkg::addrCsr, 1'b1, 1'b1, 16'h0000);
   endtask

   task automatic rxSilo();
      dzBusPkg::busWord_t d;
      dzRegPkg::char_t    c;
      dzRegPkg::lineNum_t line;
      int                 i;
      for (i = 0; i < 3; i++)
      begin
         c    = dzRegPkg::char_t'($urandom);
         line = dzRegPkg::lineNum_t'(2 * i + 1);
         sendRx(line, c);
         expRbuf.push_back(rbufWord(1'b0, line, c));
      end
      busRead(dzBusPkg::addrCsr, d);
      check("CSR.RDONE", 16'(d[dzRegPkg::csrRdoneBit]), 16'h0001);
      drainRbuf();
   endtask

   task automatic siloAlarm();
      dzBusPkg::busWord_t d;
      dzRegPkg::char_t    c;
      int                 i;
      busWrite(dzBusPkg::addrCsr, 1'b0, 1'b1, bitMask(dzRegPkg::csrSaeBit));
      for (i = 0; i < dzRegPkg::siloAlarmLevel; i++)
      begin
         // One short of the level, no alarm yet
         if (i == dzRegPkg::siloAlarmLevel - 1)
         begin
            busRead(dzBusPkg::addrCsr, d);
            check("CSR.SA", 16'(d[dzRegPkg::csrSaBit]), 16'h0000);
         end
         c = dzRegPkg::char_t'($urandom);
         sendRx(dzRegPkg::lineNum_t'(i), c);
         expRbuf.push_back(rbufWord(1'b0, dzRegPkg::lineNum_t'(i), c));
      end
      // SA trails the fill count by a cycle
      pollCsr(dzRegPkg::csrSaBit, 1'b1, 4, "SA", d);
      busRead(dzBusPkg::addrRbuf, d);
      check("RBUF", d, expRbuf.pop_front());
      busRead(dzBusPkg::addrCsr, d);
      check("CSR.SA", 16'(d[dzRegPkg::csrSaBit]), 16'h0000);
      clearDevice();
   endtask

   task automatic siloOverrun();
      dzBusPkg::busWord_t d;
      dzRegPkg::char_t    c;
      int                 i;
      // One past full, last character lost
      for (i = 0; i <= dzRegPkg::siloDepth; i++)
      begin
         c = dzRegPkg::char_t'($urandom);
         sendRx(dzRegPkg::lineNum_t'(i), c);
         if (i < dzRegPkg::siloDepth)
            expRbuf.push_back(rbufWord(1'b0, dzRegPkg::lineNum_t'(i), c));
      end
      busRead(dzBusPkg::addrRbuf, d);
      check("RBUF", d, expRbuf.pop_front());
      c = dzRegPkg::char_t'($urandom);
      sendRx(3'd7, c);
      expRbuf.push_back(rbufWord(1'b1, 3'd7, c));
      drainRbuf();
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial
   begin
      void'($urandom(32'hcfa));
      rst      = 1'b1;
      devReset = 1'b0;
      wrStrobe = 1'b0;
      rdStrobe = 1'b0;
      addr     = '0;
      loByte   = 1'b0;
      hiByte   = 1'b0;
      wrData   = '0;
      rxStrobe = 1'b0;
      rxLine   = '0;
      rxChar   = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      regAccess();
      clearOneShot();
      txScanner();
      lineDrop();
      rxSilo();
      siloAlarm();
      siloOverrun();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

//--- logic/dzMux.sv
// Eight-line serial mux top, register decode and transmit routing
// rdData is registered and holds until the next read strobe
module dzMux (
   input  logic                clk,
   input  logic                rst,
   input  logic                devReset,
   input  logic                wrStrobe,
   input  logic                rdStrobe,
   input  dzBusPkg::regAddr_t  addr,
   input  logic                loByte,
   input  logic                hiByte,
   input  dzBusPkg::busWord_t  wrData,
   output dzBusPkg::busWord_t  rdData,
   input  logic                rxStrobe,
   input  dzRegPkg::lineNum_t  rxLine,
   input  dzRegPkg::char_t     rxChar,
   output dzRegPkg::lineMask_t txStrobe,
   output dzRegPkg::char_t     txChar
);

   logic                csrWrite;
   logic                tdrWrite;
   logic                tcrWrite;
   logic                rbufRead;
   logic                tdrAccept;
   logic                siloClear;
   logic                rbufDone;
   logic                rbufAlarm;
   dzBusPkg::busWord_t  regCsr;
   dzBusPkg::busWord_t  regRbuf;
   dzBusPkg::busWord_t  regTcr;
   dzRegPkg::lineMask_t tcrLin;
   dzRegPkg::lineMask_t txEmpty;
   dzRegPkg::lineMask_t lineLoad;
   dzRegPkg::lineNum_t  tLine;
   dzRegPkg::char_t     wrChar;

   ////////////////////
   // Address decode
   ////////////////////

   // Writes to word 1 fall through, no line parameter register
   assign csrWrite = wrStrobe & (addr == dzBusPkg::addrCsr);
   assign tcrWrite = wrStrobe & (addr == dzBusPkg::addrTcr);
   assign tdrWrite = wrStrobe & (addr == dzBusPkg::addrTdr);
   assign rbufRead = rdStrobe & (addr == dzBusPkg::addrRbuf);

   // TCR, byte-lane writable, cleared with the silo
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         regTcr <= '0;
      else if (siloClear)
         regTcr <= '0;
      else if (tcrWrite)
      begin
         if (loByte)
            regTcr[dzBusPkg::loLaneLsb +: dzBusPkg::laneWidth] <=
               wrData[dzBusPkg::loLaneLsb +: dzBusPkg::laneWidth];
         if (hiByte)
            regTcr[dzBusPkg::hiLaneLsb +: dzBusPkg::laneWidth] <=
               wrData[dzBusPkg::hiLaneLsb +: dzBusPkg::laneWidth];
      end
   end

   assign tcrLin = regTcr[dzRegPkg::tcrLinLsb +: dzRegPkg::numLines];

   dzCsr i_csr (
      .clk       (clk),
      .rst       (rst),
      .devReset  (devReset),
      .csrWrite  (csrWrite),
      .tdrWrite  (tdrWrite),
      .loByte    (loByte),
      .hiByte    (hiByte),
      .wrData    (wrData),
      .tcrLin    (tcrLin),
      .txEmpty   (txEmpty),
      .rbufDone  (rbufDone),
      .rbufAlarm (rbufAlarm),
      .regCsr    (regCsr),
      .tLine     (tLine),
      .siloClear (siloClear)
   );

   dzRxSilo i_silo (
      .clk             (clk),
      .rst             (rst),
      .siloClear       (siloClear),
      .rxStrobe        (rxStrobe),
      .rxLine          (rxLine),
      .rxChar          (rxChar),
      .rbufRead        (rbufRead),
      .siloAlarmEnable (regCsr[dzRegPkg::csrSaeBit]),
      .regRbuf         (regRbuf),
      .rbufDone        (rbufDone),
      .rbufAlarm       (rbufAlarm)
   );

   ////////////////////
   // Transmit routing
   ////////////////////

   // TDR low byte only counts while TRDY is up
   assign tdrAccept = tdrWrite & loByte & regCsr[dzRegPkg::csrTrdyBit];
   assign wrChar    = wrData[dzBusPkg::loLaneLsb +: dzBusPkg::laneWidth];

   always_comb
   begin
      lineLoad = '0;
      if (tdrAccept)
         lineLoad[tLine] = 1'b1;
   end

   for (genvar i = 0; i < dzRegPkg::numLines; i++)
   begin : g_line
      dzTxLine i_txLine (
         .clk       (clk),
         .rst       (rst),
         .siloClear (siloClear),
         .load      (lineLoad[i]),
         .char      (wrChar),
         .txEmpty   (txEmpty[i])
      );
   end

   // One-cycle line strobe after the accepted write
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         txStrobe <= '0;
      else
         txStrobe <= lineLoad;
   end

   always_ff @(posedge clk)
   begin
      if (tdrAccept)
         txChar <= wrChar;
   end

   // Registered read mux, TDR reads as zero
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         rdData <= '0;
      else if (rdStrobe)
      begin
         case (addr)
            dzBusPkg::addrCsr:  rdData <= regCsr;
            dzBusPkg::addrRbuf: rdData <= regRbuf;
            dzBusPkg::addrTcr:  rdData <= regTcr;
            default:            rdData <= '0;
         endcase
      end
   end

endmodule

//--- logic/dzCsr.sv
// CSR with clear one-shot, enable bits and the transmitter scanner
// CLR length is a fixed cycle count, not derived from a clock rate
module dzCsr (
   input  logic                clk,
   input  logic                rst,
   input  logic                devReset,
   input  logic                csrWrite,
   input  logic                tdrWrite,
   input  logic                loByte,
   input  logic                hiByte,
   input  dzBusPkg::busWord_t  wrData,
   input  dzRegPkg::lineMask_t tcrLin,
   input  dzRegPkg::lineMask_t txEmpty,
   input  logic                rbufDone,
   input  logic                rbufAlarm,
   output dzBusPkg::busWord_t  regCsr,
   output dzRegPkg::lineNum_t  tLine,
   output logic                siloClear
);

   typedef logic [$clog2(dzRegPkg::clrCycles + 1)-1:0] clrCount_t;

   clrCount_t            clrCount;
   logic                 csrClr;
   logic                 tie, sae, rie, mse, maint;
   logic                 tieNext, saeNext, rieNext, mseNext, maintNext;
   dzRegPkg::scanState_t scanState;
   dzRegPkg::lineNum_t   scan;
   logic                 trdy;
   logic                 tdrLoWrite;

   ////////////////////
   // Clear one-shot
   ////////////////////

   // A new CLR write restarts the count even during devReset
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         clrCount <= '0;
      else if (csrWrite & loByte & wrData[dzRegPkg::csrClrBit])
         clrCount <= clrCount_t'(dzRegPkg::clrCycles);
      else if (devReset)
         clrCount <= '0;
      else if (clrCount != '0)
         clrCount <= clrCount - 1'b1;
   end

   assign csrClr    = (clrCount != '0);
   assign siloClear = csrClr | devReset;

   ////////////////////
   // Enable bits
   ////////////////////

   // Next values, also seen by the scanner so MSE and state move together
   always_comb
   begin
      tieNext   = tie;
      saeNext   = sae;
      rieNext   = rie;
      mseNext   = mse;
      maintNext = maint;
      if (siloClear)
      begin
         tieNext   = 1'b0;
         saeNext   = 1'b0;
         rieNext   = 1'b0;
         mseNext   = 1'b0;
         maintNext = 1'b0;
      end
      else if (csrWrite)
      begin
         // High lane
         if (hiByte)
         begin
            tieNext = wrData[dzRegPkg::csrTieBit];
            saeNext = wrData[dzRegPkg::csrSaeBit];
         end
         // Low lane
         if (loByte)
         begin
            rieNext   = wrData[dzRegPkg::csrRieBit];
            mseNext   = wrData[dzRegPkg::csrMseBit];
            maintNext = wrData[dzRegPkg::csrMaintBit];
         end
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         tie   <= 1'b0;
         sae   <= 1'b0;
         rie   <= 1'b0;
         mse   <= 1'b0;
         maint <= 1'b0;
      end
      else
      begin
         tie   <= tieNext;
         sae   <= saeNext;
         rie   <= rieNext;
         mse   <= mseNext;
         maint <= maintNext;
      end
   end

   ////////////////////
   // Transmitter scanner
   ////////////////////

   assign tdrLoWrite = tdrWrite & loByte;

   // One line checked per cycle, index kept across a served write
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         scan      <= '0;
         tLine     <= '0;
         scanState <= dzRegPkg::scanIdle;
      end
      else if (siloClear)
      begin
         scan      <= '0;
         tLine     <= '0;
         scanState <= dzRegPkg::scanIdle;
      end
      else
      begin
         case (scanState)
            dzRegPkg::scanIdle:
            begin
               if (mseNext & tcrLin[scan] & txEmpty[scan])
               begin
                  tLine     <= scan;
                  scanState <= dzRegPkg::scanHold;
               end
               else if (mseNext)
                  scan <= scan + 1'b1;
            end
            // Held line dropped when disabled or scanning switched off
            dzRegPkg::scanHold:
            begin
               if (!mseNext | !tcrLin[tLine])
                  scanState <= dzRegPkg::scanIdle;
               else if (tdrLoWrite)
                  scanState <= dzRegPkg::scanWait;
            end
            // Wait for the write strobe to go away
            dzRegPkg::scanWait:
            begin
               if (!tdrLoWrite)
                  scanState <= dzRegPkg::scanIdle;
            end
            default:
               scanState <= dzRegPkg::scanIdle;
         endcase
      end
   end

   assign trdy = (scanState == dzRegPkg::scanHold);

   // CSR word, unused bits read as zero
   always_comb
   begin
      regCsr = '0;
      regCsr[dzRegPkg::csrTrdyBit]  = trdy;
      regCsr[dzRegPkg::csrTieBit]   = tie;
      regCsr[dzRegPkg::csrSaBit]    = rbufAlarm;
      regCsr[dzRegPkg::csrSaeBit]   = sae;
      regCsr[dzRegPkg::csrTlineLsb +: $bits(dzRegPkg::lineNum_t)] = tLine;
      regCsr[dzRegPkg::csrRdoneBit] = rbufDone;
      regCsr[dzRegPkg::csrRieBit]   = rie;
      regCsr[dzRegPkg::csrMseBit]   = mse;
      regCsr[dzRegPkg::csrClrBit]   = csrClr;
      regCsr[dzRegPkg::csrMaintBit] = maint;
   end

   stateLegal: assert property (@(posedge clk) disable iff (rst)
      scanState inside {dzRegPkg::scanIdle, dzRegPkg::scanHold, dzRegPkg::scanWait});

   // MSE register and scanner state must drop on the same edge
   trdyNeedsMse: assert property (@(posedge clk) disable iff (rst)
      trdy |-> mse);

endmodule

//--- logic/dzRxSilo.sv
// Receive silo of line-tagged characters, head shown in RBUF
// Depth must be a power of two, pointers wrap naturally
module dzRxSilo (
   input  logic               clk,
   input  logic               rst,
   input  logic               siloClear,
   input  logic               rxStrobe,
   input  dzRegPkg::lineNum_t rxLine,
   input  dzRegPkg::char_t    rxChar,
   input  logic               rbufRead,
   input  logic               siloAlarmEnable,
   output dzBusPkg::busWord_t regRbuf,
   output logic               rbufDone,
   output logic               rbufAlarm
);

   typedef logic [$clog2(dzRegPkg::siloDepth)-1:0] siloPtr_t;
   typedef logic [$clog2(dzRegPkg::siloDepth + 1)-1:0] siloCount_t;
   // Entry layout is {ovrn, line, char}
   typedef logic [$bits(dzRegPkg::lineNum_t) + $bits(dzRegPkg::char_t):0] siloEntry_t;

   siloEntry_t siloMem [dzRegPkg::siloDepth];
   siloEntry_t head;
   siloPtr_t   wrPtr;
   siloPtr_t   rdPtr;
   siloCount_t count;
   logic       full;
   logic       empty;
   logic       push;
   logic       pop;
   logic       ovrnPending;
   logic       alarm;

   assign full  = (count == siloCount_t'(dzRegPkg::siloDepth));
   assign empty = (count == '0);

   // Nothing enters or leaves while the silo is being cleared
   assign push = rxStrobe & !full & !siloClear;
   assign pop  = rbufRead & !empty & !siloClear;

   ////////////////////
   // Storage
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (push)
         siloMem[wrPtr] <= {ovrnPending, rxLine, rxChar};
   end

   // Pointers and fill count
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end
      else if (siloClear)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end
      else
      begin
         if (push)
            wrPtr <= wrPtr + 1'b1;
         if (pop)
            rdPtr <= rdPtr + 1'b1;
         if (push & !pop)
            count <= count + 1'b1;
         else if (pop & !push)
            count <= count - 1'b1;
      end
   end

   ////////////////////
   // Overrun and alarm
   ////////////////////

   // Lost character flagged in the next stored entry
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         ovrnPending <= 1'b0;
      else if (siloClear | push)
         ovrnPending <= 1'b0;
      else if (rxStrobe & full)
         ovrnPending <= 1'b1;
   end

   // Alarm trails the fill level by a cycle, an RBUF read clears it
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         alarm <= 1'b0;
      else if (siloClear | !siloAlarmEnable | rbufRead)
         alarm <= 1'b0;
      else if (count >= siloCount_t'(dzRegPkg::siloAlarmLevel))
         alarm <= 1'b1;
   end

   assign rbufAlarm = alarm;
   assign rbufDone  = !empty;
   assign head      = siloMem[rdPtr];

   // Head entry with DVAL, empty silo reads as zero
   always_comb
   begin
      regRbuf = '0;
      if (!empty)
      begin
         regRbuf[dzRegPkg::rbufDvalBit] = 1'b1;
         regRbuf[dzRegPkg::rbufOvrnBit] = head[$bits(siloEntry_t)-1];
         regRbuf[dzRegPkg::rbufLineLsb +: $bits(dzRegPkg::lineNum_t)] =
            head[$bits(dzRegPkg::char_t) +: $bits(dzRegPkg::lineNum_t)];
         regRbuf[dzRegPkg::rbufCharLsb +: $bits(dzRegPkg::char_t)] =
            head[0 +: $bits(dzRegPkg::char_t)];
      end
   end

   countBound: assert property (@(posedge clk) disable iff (rst)
      count <= siloCount_t'(dzRegPkg::siloDepth));

endmodule

//--- logic/dzTxLine.sv
// Transmitter model of one line, a fixed busy time per character
// No serial output, the character is only taken in
module dzTxLine (
   input  logic            clk,
   input  logic            rst,
   input  logic            siloClear,
   input  logic            load,
   input  dzRegPkg::char_t char,
   output logic            txEmpty
);

   typedef logic [$clog2(dzRegPkg::txCharCycles + 1)-1:0] busyCount_t;

   busyCount_t busyCount;

   ////////////////////
   // Character time
   ////////////////////

   // Clear cancels a character in flight
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         busyCount <= '0;
      else if (siloClear)
         busyCount <= '0;
      else if (load)
         busyCount <= busyCount_t'(dzRegPkg::txCharCycles);
      else if (busyCount != '0)
         busyCount <= busyCount - 1'b1;
   end

   // Empty again txCharCycles after the load
   assign txEmpty = (busyCount == '0);

   // Scanner must only serve idle lines, and with a real character
   loadWhenEmpty: assert property (@(posedge clk) disable iff (rst)
      load |-> txEmpty && !$isunknown(char));

endmodule

//--- logic/dzRegPkg.sv
// Register layout, line types and timing constants of the DZ mux
// Silo depth is assumed to be a power of two
package dzRegPkg;

   // Eight lines per mux
   localparam int numLines = 8;

   typedef logic [2:0] lineNum_t;
   typedef logic [numLines-1:0] lineMask_t;
   typedef logic [7:0] char_t;

   ////////////////////
   // CSR bits
   ////////////////////

   localparam int csrTrdyBit  = 15;
   localparam int csrTieBit   = 14;
   localparam int csrSaBit    = 13;
   localparam int csrSaeBit   = 12;
   // TLINE occupies 10:8
   localparam int csrTlineLsb = 8;
   localparam int csrRdoneBit = 7;
   localparam int csrRieBit   = 6;
   localparam int csrMseBit   = 5;
   localparam int csrClrBit   = 4;
   localparam int csrMaintBit = 3;

   ////////////////////
   // RBUF and TCR bits
   ////////////////////

   localparam int rbufDvalBit = 15;
   localparam int rbufOvrnBit = 14;
   localparam int rbufLineLsb = 8;
   localparam int rbufCharLsb = 0;
   // Line enables in the low byte
   localparam int tcrLinLsb   = 0;

   // Timing and silo sizing, all in clock cycles or entries
   localparam int clrCycles      = 16;
   localparam int siloDepth      = 16;
   localparam int siloAlarmLevel = 8;
   localparam int txCharCycles   = 12;

   // Transmitter scanner
   typedef enum logic [1:0] {scanIdle, scanHold, scanWait} scanState_t;

endpackage

//--- logic/dzBusPkg.sv
// Host bus types for the DZ mux register file
// 16-bit little-endian word bus with two byte lanes
package dzBusPkg;

   // Host data word
   typedef logic [15:0] busWord_t;

   // Register word select
   typedef logic [1:0] regAddr_t;

   ////////////////////
   // Register words
   ////////////////////

   localparam regAddr_t addrCsr  = 2'd0;
   // Reads only, writes would go to the line parameter register
   localparam regAddr_t addrRbuf = 2'd1;
   localparam regAddr_t addrTcr  = 2'd2;
   // Write only, reads back as zero
   localparam regAddr_t addrTdr  = 2'd3;

   ////////////////////
   // Byte lanes
   ////////////////////

   // loByte strobes bits 7:0, hiByte strobes bits 15:8
   localparam int laneWidth = 8;
   localparam int loLaneLsb = 0;
   localparam int hiLaneLsb = 8;

endpackage
